/* verilog.f */
+incdir+logic
logic/shapes_pkg.sv
logic/display_timing.sv
logic/draw_rect_fill.sv
logic/draw_tri_fill.sv
logic/shape_dispatch.sv
logic/framebuffer.sv
logic/video_compose.sv
logic/shapes_top.sv
test/tb_shapes.sv

/* run_sim.sh */
#!/bin/sh
# build the shape renderer testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal --top-module tb_shapes -f verilog.f -Mdir obj_dir &&
{ ./obj_dir/Vtb_shapes > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "No errors" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* test/tb_shapes.sv */
// shape renderer testbench
// drives shape commands over the req/ack port and checks whole frames against a shadow fb
`timescale 1ns/1ns
`default_nettype none
`include "shapes_defs.svh"

module tb_shapes;
    import shapes_pkg::*;

    localparam int DIRECTED_CMDS = 10;
    localparam int RAND_CMDS     = 20;
    localparam int FRAME_CYCLES  = `SHP_H_TOT * `SHP_V_TOT;
    localparam int FRAME_PIX     = `SHP_H_ACT * `SHP_V_ACT;
    localparam int TIMEOUT       = (DIRECTED_CMDS + RAND_CMDS + 4) * 2 * FRAME_CYCLES;

    logic        clk_pix;
    logic        rst_n;
    shape_t      cmd;
    logic        cmd_req;
    logic        cmd_ack;
    sync_t       sync;
    rgb_t        rgb;

    cidx_t       shadow [`SHP_FB_H][`SHP_FB_W];  // expected index memory
    logic [31:0] lcg_state = 32'h8b0a3b08;
    int          cycles    = 0;
    int          n_checks  = 0;
    logic        check_req = 1'b0;  // hands a frame compare to the checker

    shapes_top u_shapes_top (
        .clk_pix,
        .rst_n,
        .cmd,
        .cmd_req,
        .cmd_ack,
        .sync,
        .rgb
    );

    always #20 clk_pix = ~clk_pix;

    task automatic report_fail(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) report_fail($sformatf("timeout after %0d cycles", cycles));
    end

    task automatic check_rgb(rgb_t got, rgb_t exp, int dx, int dy);
        n_checks++;
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH at %0t ns: rgb at (%0d,%0d) is %03h, expected %03h",
                                  $time, dx, dy, got, exp));
        end
    endtask

    task automatic check_sync(string what, int got, int exp);
        n_checks++;
        if (got != exp) begin
            report_fail($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
                                  $time, what, got, exp));
        end
    endtask

    task automatic check_ack(logic got, logic exp, string what);
        n_checks++;
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH at %0t ns: %s, cmd_ack is %b", $time, what, got));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic coord_t rand_coord(int span, int off);
        return coord_t'(int'(next_rand() >> 16) % span - off);
    endfunction

    function automatic int imin(int a, int b);
        return (a < b) ? a : b;
    endfunction

    function automatic int imax(int a, int b);
        return (a > b) ? a : b;
    endfunction

    // inclusive box, corner order free
    function automatic bit rect_in(shape_t s, int x, int y);
        return x >= imin(s.x0, s.x1) && x <= imax(s.x0, s.x1)
            && y >= imin(s.y0, s.y1) && y <= imax(s.y0, s.y1);
    endfunction

    function automatic bit tri_in(shape_t s, int x, int y);
        int vx [3];
        int vy [3];
        int e [3];
        vx[0] = s.x0;
        vy[0] = s.y0;
        vx[1] = s.x1;
        vy[1] = s.y1;
        vx[2] = s.x2;
        vy[2] = s.y2;
        if (x < imin(vx[0], imin(vx[1], vx[2])) || x > imax(vx[0], imax(vx[1], vx[2])))
            return 1'b0;
        if (y < imin(vy[0], imin(vy[1], vy[2])) || y > imax(vy[0], imax(vy[1], vy[2])))
            return 1'b0;
        for (int i = 0; i < 3; i++) begin
            e[i] = (x - vx[i]) * (vy[(i + 1) % 3] - vy[i])
                 - (y - vy[i]) * (vx[(i + 1) % 3] - vx[i]);
        end
        return (e[0] >= 0 && e[1] >= 0 && e[2] >= 0) || (e[0] <= 0 && e[1] <= 0 && e[2] <= 0);
    endfunction

    // only fb pixels are visited, so clipping comes for free
    task automatic apply_shape(shape_t s);
        bit hit;
        for (int y = 0; y < `SHP_FB_H; y++) begin
            for (int x = 0; x < `SHP_FB_W; x++) begin
                hit = (s.kind == SHAPE_RECT) ? rect_in(s, x, y) : tri_in(s, x, y);
                if (hit) shadow[y][x] = s.cidx;
            end
        end
    endtask

    function automatic rgb_t ref_rgb(int dx, int dy);
        cidx_t idx;
        rgb_t  c;
        idx = shadow[dy / `SHP_SCALE][dx / `SHP_SCALE];
        if (idx != '0) begin
            c = palette(idx);
        end else begin
            c.red   = 4'h0;  // gradient behind index 0
            c.green = 4'h2;
            c.blue  = 4'(dy / 4);
        end
        return c;
    endfunction

    function automatic shape_t mk_rect(int x0, int y0, int x1, int y1, int c);
        shape_t s;
        s      = '0;
        s.kind = SHAPE_RECT;
        s.x0   = coord_t'(x0);
        s.y0   = coord_t'(y0);
        s.x1   = coord_t'(x1);
        s.y1   = coord_t'(y1);
        s.cidx = cidx_t'(c);
        return s;
    endfunction

    function automatic shape_t mk_tri(int x0, int y0, int x1, int y1, int x2, int y2, int c);
        shape_t s;
        s      = mk_rect(x0, y0, x1, y1, c);
        s.kind = SHAPE_TRI;
        s.x2   = coord_t'(x2);
        s.y2   = coord_t'(y2);
        return s;
    endfunction

    function automatic shape_t rand_shape();
        shape_t s;
        logic [31:0] r;
        r = next_rand();
        s = mk_tri(rand_coord(44, 6), rand_coord(36, 6), rand_coord(44, 6),
                   rand_coord(36, 6), rand_coord(44, 6), rand_coord(36, 6), r[19:16]);
        if (!r[23]) s.kind = SHAPE_RECT;
        return s;
    endfunction

    // four-phase handshake, one command
    task automatic send_cmd(shape_t s);
        @(negedge clk_pix);
        check_ack(cmd_ack, 1'b0, "ack high before request");
        @(posedge clk_pix);
        cmd     <= s;
        cmd_req <= 1'b1;
        do @(negedge clk_pix); while (cmd_ack !== 1'b1);
        @(posedge clk_pix);
        cmd_req <= 1'b0;
        @(negedge clk_pix);
        check_ack(cmd_ack, 1'b1, "ack dropped before request was seen low");
        @(negedge clk_pix);
        check_ack(cmd_ack, 1'b0, "ack still high a cycle after request dropped");
        apply_shape(s);
    endtask

    // returns at the first sample with vsync low
    task automatic wait_vsync_fall();
        logic prev;
        @(negedge clk_pix);
        prev = sync.vsync;
        @(negedge clk_pix);
        while (!(prev && !sync.vsync)) begin
            prev = sync.vsync;
            @(negedge clk_pix);
        end
    endtask

    task automatic measure_timing();
        int de_run;
        int de_lines;
        int hs_run;
        int hs_lines;
        int vs_low;
        de_run   = 0;
        de_lines = 0;
        hs_run   = 0;
        hs_lines = 0;
        vs_low   = 0;
        wait_vsync_fall();
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (sync.de) begin
                de_run++;
            end else if (de_run != 0) begin
                check_sync("de cycles in a line", de_run, `SHP_H_ACT);
                de_lines++;
                de_run = 0;
            end
            if (!sync.hsync) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_sync("hsync low cycles", hs_run, `SHP_H_SYNC);
                hs_lines++;
                hs_run = 0;
            end
            if (!sync.vsync) vs_low++;
            @(negedge clk_pix);
        end
        check_sync("de lines per frame", de_lines, `SHP_V_ACT);
        check_sync("hsync pulses per frame", hs_lines, `SHP_V_TOT);
        check_sync("vsync low cycles per frame", vs_low, `SHP_V_SYNC * `SHP_H_TOT);
    endtask

    // frame checker, counts de pixels from the vsync edge
    always begin : frame_checker
        int n;
        wait (check_req);
        wait_vsync_fall();
        n = 0;
        while (n < FRAME_PIX) begin
            @(negedge clk_pix);
            if (sync.de) begin
                check_rgb(rgb, ref_rgb(n % `SHP_H_ACT, n / `SHP_H_ACT),
                          n % `SHP_H_ACT, n / `SHP_H_ACT);
                n++;
            end
        end
        check_req = 1'b0;
    end

    task automatic compare_frame();
        check_req = 1'b1;
        wait (!check_req);
    endtask

    initial begin
        clk_pix = 1'b0;
        rst_n   = 1'b0;
        cmd     = '0;
        cmd_req = 1'b0;
        for (int y = 0; y < `SHP_FB_H; y++) begin
            for (int x = 0; x < `SHP_FB_W; x++) shadow[y][x] = '0;
        end
        repeat (2) @(posedge clk_pix);
        rst_n <= 1'b1;
        @(negedge clk_pix);
        check_ack(cmd_ack, 1'b0, "ack high after reset");
        measure_timing();

        // full screen, background then solid
        send_cmd(mk_rect(0, 0, 31, 23, 0));
        compare_frame();
        send_cmd(mk_rect(31, 23, 0, 0, 5));
        compare_frame();

        // overlapping boxes, corners reversed
        send_cmd(mk_rect(20, 15, 4, 3, 3));
        compare_frame();
        send_cmd(mk_rect(25, 18, 10, 8, 9));
        compare_frame();

        // both windings and a collinear triangle
        send_cmd(mk_tri(2, 2, 28, 5, 10, 20, 12));
        compare_frame();
        send_cmd(mk_tri(30, 22, 16, 1, 3, 14, 14));
        compare_frame();
        send_cmd(mk_tri(1, 1, 29, 15, 15, 8, 7));
        compare_frame();

        // past the fb edges
        send_cmd(mk_rect(-5, -4, 6, 5, 10));
        compare_frame();
        send_cmd(mk_rect(28, 20, 40, 30, 11));
        compare_frame();
        send_cmd(mk_tri(-8, 10, 12, -6, 36, 26, 2));
        compare_frame();

        for (int k = 0; k < RAND_CMDS; k++) send_cmd(rand_shape());
        compare_frame();

        if (n_checks > 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_fail("no checks were run");
        end
    end

endmodule

`default_nettype wire

/* logic/shapes_top.sv */
// shape renderer top level
// command port, drawers, framebuffer and video output path
`timescale 1ns/1ns
`default_nettype none

module shapes_top (
    input  wire logic               clk_pix,
    input  wire logic               rst_n,
    input  wire shapes_pkg::shape_t cmd,
    input  wire logic               cmd_req,
    output logic                    cmd_ack,
    output shapes_pkg::sync_t       sync,
    output shapes_pkg::rgb_t        rgb
);
    import shapes_pkg::*;

    coord_t  sx, sy;     // raster position
    sync_t   sync_raw;   // undelayed timing
    pix_wr_t wr;
    cidx_t   fb_cidx;
    rgb_t    fb_rgb;

    display_timing u_timing (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .sync  (sync_raw),
        .frame (),
        .line  ()
    );

    shape_dispatch u_dispatch (
        .clk_pix,
        .rst_n,
        .cmd,
        .cmd_req,
        .cmd_ack,
        .wr
    );

    framebuffer u_fb (
        .clk_pix,
        .rst_n,
        .wr,
        .sx,
        .sy,
        .cidx (fb_cidx),
        .rgb  (fb_rgb)
    );

    video_compose u_compose (
        .clk_pix,
        .rst_n,
        .sync_in  (sync_raw),
        .sy,
        .cidx     (fb_cidx),
        .rgb_in   (fb_rgb),
        .sync_out (sync),
        .rgb
    );

endmodule

`default_nettype wire

/* logic/video_compose.sv */
// video output stage
// realigns syncs with the fb read and picks shape or gradient colour
`timescale 1ns/1ns
`default_nettype none

module video_compose (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire shapes_pkg::sync_t sync_in,
    input  wire shapes_pkg::coord_t sy,
    input  wire shapes_pkg::cidx_t cidx,
    input  wire shapes_pkg::rgb_t  rgb_in,
    output shapes_pkg::sync_t      sync_out,
    output shapes_pkg::rgb_t       rgb
);
    import shapes_pkg::*;

    localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};

    sync_t  sync_d;  // matches fb read latency
    coord_t sy_d;
    rgb_t   bg;

    always_ff @(posedge clk_pix) begin
        sy_d <= sy;
    end

    // blue steps every 4 lines
    always_comb begin
        bg.red   = 4'h0;
        bg.green = 4'h2;
        bg.blue  = 4'(sy_d / 4);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sync_d   <= SYNC_IDLE;
            sync_out <= SYNC_IDLE;
            rgb      <= '0;
        end else begin
            sync_d   <= sync_in;
            sync_out <= sync_d;
            if (!sync_d.de) begin
                rgb <= '0;  // black in blanking
            end else if (cidx != '0) begin
                rgb <= rgb_in;
            end else begin
                rgb <= bg;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/framebuffer.sv */
// indexed-colour framebuffer
// pixel write port, scaled raster read port and palette lookup
`timescale 1ns/1ns
`default_nettype none
`include "shapes_defs.svh"

module framebuffer (
    input  wire logic                clk_pix,
    input  wire logic                rst_n,
    input  wire shapes_pkg::pix_wr_t wr,
    input  wire shapes_pkg::coord_t  sx,
    input  wire shapes_pkg::coord_t  sy,
    output shapes_pkg::cidx_t        cidx,
    output shapes_pkg::rgb_t         rgb
);
    import shapes_pkg::*;

    localparam int DEPTH = `SHP_FB_W * `SHP_FB_H;
    localparam int AW    = $clog2(DEPTH);

    cidx_t         mem [DEPTH];
    coord_t        fx, fy;    // raster position in fb pixels
    logic          wr_in;
    logic          rd_in;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    cidx_t         cidx_q;

    always_comb begin
        // clipping happens here only
        wr_in   = (wr.x >= 0) && (wr.x < `SHP_FB_W) && (wr.y >= 0) && (wr.y < `SHP_FB_H);
        wr_addr = AW'(wr.y) * AW'(`SHP_FB_W) + AW'(wr.x);
        fx      = coord_t'(sx / `SHP_SCALE);
        fy      = coord_t'(sy / `SHP_SCALE);
        rd_in   = (fx >= 0) && (fx < `SHP_FB_W) && (fy >= 0) && (fy < `SHP_FB_H);
        rd_addr = AW'(fy) * AW'(`SHP_FB_W) + AW'(fx);
    end

    always_ff @(posedge clk_pix) begin
        if (wr.valid && wr_in) mem[wr_addr] <= wr.cidx;
    end

    // blanking area reads as index 0
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            cidx_q <= '0;
        end else begin
            cidx_q <= rd_in ? mem[rd_addr] : '0;
        end
    end

    always_comb begin
        cidx = cidx_q;
        rgb  = palette(cidx_q);
    end

endmodule

`default_nettype wire

/* logic/shape_dispatch.sv */
// shape command dispatcher
// four-phase req/ack port, drawer selection and merged pixel writes
`timescale 1ns/1ns
`default_nettype none

module shape_dispatch (
    input  wire logic               clk_pix,
    input  wire logic               rst_n,
    input  wire shapes_pkg::shape_t cmd,
    input  wire logic               cmd_req,
    output logic                    cmd_ack,
    output shapes_pkg::pix_wr_t     wr
);
    import shapes_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DRAW,
        ACK,
        RELEASE
    } state_t;

    state_t  state;
    shape_t  shape_q;
    logic    start_rect, start_tri;
    logic    done_rect, done_tri;
    logic    draw_done;
    pix_wr_t pix_rect, pix_tri;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state      <= IDLE;
            start_rect <= 1'b0;
            start_tri  <= 1'b0;
        end else begin
            start_rect <= 1'b0;
            start_tri  <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_req) begin
                        start_rect <= (cmd.kind == SHAPE_RECT);
                        start_tri  <= (cmd.kind == SHAPE_TRI);
                        state      <= DRAW;
                    end
                end
                DRAW: begin
                    if (draw_done) state <= ACK;  // last pixel written this edge
                end
                ACK: begin
                    if (!cmd_req) state <= RELEASE;
                end
                RELEASE: state <= IDLE;  // ack low for a cycle before next req
                default: state <= IDLE;
            endcase
        end
    end

    // command held for the whole draw
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && cmd_req) shape_q <= cmd;
    end

    always_comb begin
        draw_done = done_rect || done_tri;
        cmd_ack   = (state == ACK);
        wr        = pix_rect | pix_tri;  // only one drawer active
    end

    draw_rect_fill u_rect (
        .clk_pix,
        .rst_n,
        .start (start_rect),
        .shape (shape_q),
        .pix   (pix_rect),
        .done  (done_rect)
    );

    draw_tri_fill u_tri (
        .clk_pix,
        .rst_n,
        .start (start_tri),
        .shape (shape_q),
        .pix   (pix_tri),
        .done  (done_tri)
    );

    assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(draw_done))
        else $error("cmd_ack raised without a finished draw");

endmodule

`default_nettype wire

/* logic/draw_tri_fill.sv */
// filled triangle drawer
// scans the bounding box and keeps pixels where all edge functions agree in sign
`timescale 1ns/1ns
`default_nettype none
`include "shapes_defs.svh"

module draw_tri_fill (
    input  wire logic               clk_pix,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire shapes_pkg::shape_t shape,
    output shapes_pkg::pix_wr_t     pix,
    output logic                    done
);
    import shapes_pkg::*;

    localparam int EW = 2 * `SHP_CORDW + 4;  // edge function width

    typedef logic signed [EW-1:0] edge_t;

    edge_t  vx [3];
    edge_t  vy [3];
    edge_t  e_init [3];  // edge values at top-left of box
    edge_t  e [3];       // edge values at (x, y)
    edge_t  e_row [3];   // edge values at start of current row
    edge_t  step_x [3];
    edge_t  step_y [3];
    coord_t bx_lo, bx_hi, by_lo, by_hi;
    coord_t x, y;
    coord_t x_min, x_max, y_max;
    cidx_t  colr;
    logic   busy;
    logic   last;
    logic   in_tri;

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    always_comb begin
        vx[0] = edge_t'(shape.x0);
        vy[0] = edge_t'(shape.y0);
        vx[1] = edge_t'(shape.x1);
        vy[1] = edge_t'(shape.y1);
        vx[2] = edge_t'(shape.x2);
        vy[2] = edge_t'(shape.y2);
        bx_lo = min3(shape.x0, shape.x1, shape.x2);
        bx_hi = max3(shape.x0, shape.x1, shape.x2);
        by_lo = min3(shape.y0, shape.y1, shape.y2);
        by_hi = max3(shape.y0, shape.y1, shape.y2);
        // edge i runs from vertex i to vertex i+1
        for (int i = 0; i < 3; i++) begin
            e_init[i] = (edge_t'(bx_lo) - vx[i]) * (vy[(i + 1) % 3] - vy[i])
                      - (edge_t'(by_lo) - vy[i]) * (vx[(i + 1) % 3] - vx[i]);
        end
    end

    always_comb begin
        last   = busy && (x == x_max) && (y == y_max);
        // both windings fill and collinear points give all zero
        in_tri = ((e[0] >= 0) && (e[1] >= 0) && (e[2] >= 0))
              || ((e[0] <= 0) && (e[1] <= 0) && (e[2] <= 0));
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (start) begin
            x     <= bx_lo;
            y     <= by_lo;
            x_min <= bx_lo;
            x_max <= bx_hi;
            y_max <= by_hi;
            colr  <= shape.cidx;
            for (int i = 0; i < 3; i++) begin
                e[i]      <= e_init[i];
                e_row[i]  <= e_init[i];
                step_x[i] <= vy[(i + 1) % 3] - vy[i];
                step_y[i] <= vx[i] - vx[(i + 1) % 3];
            end
        end else if (busy) begin
            if (x == x_max) begin  // back to left edge one row down
                x <= x_min;
                y <= y + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e[i]     <= e_row[i] + step_y[i];
                    e_row[i] <= e_row[i] + step_y[i];
                end
            end else begin
                x <= x + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    e[i] <= e[i] + step_x[i];
                end
            end
        end
    end

    always_comb begin
        pix  = '0;
        done = last;  // end of box scan
        if (busy && in_tri) begin
            pix.valid = 1'b1;
            pix.x     = x;
            pix.y     = y;
            pix.cidx  = colr;
        end
    end

endmodule

`default_nettype wire

/* logic/draw_rect_fill.sv */
// filled rectangle drawer
// sorts the two corners, then emits one pixel per clock row by row
`timescale 1ns/1ns
`default_nettype none

module draw_rect_fill (
    input  wire logic               clk_pix,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire shapes_pkg::shape_t shape,
    output shapes_pkg::pix_wr_t     pix,
    output logic                    done
);
    import shapes_pkg::*;

    coord_t x_lo, x_hi, y_lo, y_hi;  // sorted corners of incoming shape
    coord_t x, y;                    // scan position
    coord_t x_min, x_max, y_max;     // latched box
    cidx_t  colr;
    logic   busy;
    logic   last;

    always_comb begin
        x_lo = (shape.x0 < shape.x1) ? shape.x0 : shape.x1;
        x_hi = (shape.x0 < shape.x1) ? shape.x1 : shape.x0;
        y_lo = (shape.y0 < shape.y1) ? shape.y0 : shape.y1;
        y_hi = (shape.y0 < shape.y1) ? shape.y1 : shape.y0;
        last = busy && (x == x_max) && (y == y_max);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (start) begin
            x     <= x_lo;
            y     <= y_lo;
            x_min <= x_lo;
            x_max <= x_hi;
            y_max <= y_hi;
            colr  <= shape.cidx;
        end else if (busy) begin
            if (x == x_max) begin  // next row
                x <= x_min;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // zero when idle so the dispatcher can OR both drawers
    always_comb begin
        pix  = '0;
        done = last;
        if (busy) begin
            pix.valid = 1'b1;
            pix.x     = x;
            pix.y     = y;
            pix.cidx  = colr;
        end
    end

    assert property (@(posedge clk_pix) disable iff (!rst_n) start |-> !busy)
        else $error("rectangle start while still drawing");

endmodule

`default_nettype wire

/* logic/display_timing.sv */
// display timing generator
// raster counters, active-low syncs, data enable and frame/line strobes
`timescale 1ns/1ns
`default_nettype none
`include "shapes_defs.svh"

module display_timing (
    input  wire logic          clk_pix,
    input  wire logic          rst_n,
    output shapes_pkg::coord_t sx,
    output shapes_pkg::coord_t sy,
    output shapes_pkg::sync_t  sync,
    output logic               frame,
    output logic               line
);
    import shapes_pkg::*;

    localparam coord_t H_LAST   = coord_t'(`SHP_H_TOT - 1);
    localparam coord_t V_LAST   = coord_t'(`SHP_V_TOT - 1);
    localparam coord_t H_ACT    = coord_t'(`SHP_H_ACT);
    localparam coord_t V_ACT    = coord_t'(`SHP_V_ACT);
    localparam coord_t HS_START = coord_t'(`SHP_H_ACT + `SHP_H_FP);
    localparam coord_t HS_END   = coord_t'(`SHP_H_ACT + `SHP_H_FP + `SHP_H_SYNC);
    localparam coord_t VS_START = coord_t'(`SHP_V_ACT + `SHP_V_FP);
    localparam coord_t VS_END   = coord_t'(`SHP_V_ACT + `SHP_V_FP + `SHP_V_SYNC);

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;  // wrap at end of frame
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decoded straight from the counters so reset gives de=1, syncs high
    always_comb begin
        sync.hsync = !(sx >= HS_START && sx < HS_END);
        sync.vsync = !(sy >= VS_START && sy < VS_END);
        sync.de    = (sx < H_ACT) && (sy < V_ACT);
        frame      = (sx == '0) && (sy == '0);
        line       = (sx == '0);
    end

    assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx < coord_t'(`SHP_H_TOT))
        else $error("sx ran past the line length");

endmodule

`default_nettype wire

/* logic/shapes_pkg.sv */
// shape renderer shared types
// command, pixel write and video structs plus the fixed 16-colour palette
`include "shapes_defs.svh"
`default_nettype none

package shapes_pkg;

    typedef logic signed [`SHP_CORDW-1:0] coord_t;
    typedef logic [`SHP_CIDXW-1:0] cidx_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef enum logic {
        SHAPE_RECT = 1'b0,
        SHAPE_TRI  = 1'b1
    } shape_kind_t;

    // rect uses only the first two vertices
    typedef struct packed {
        shape_kind_t kind;
        coord_t      x0;
        coord_t      y0;
        coord_t      x1;
        coord_t      y1;
        coord_t      x2;
        coord_t      y2;
        cidx_t       cidx;
    } shape_t;

    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pix_wr_t;

    typedef struct packed {
        logic hsync;  // active low
        logic vsync;  // active low
        logic de;
    } sync_t;

    function automatic rgb_t palette(cidx_t idx);
        case (idx)
            4'h0: return rgb_t'(12'h000);  // black, shows background
            4'h1: return rgb_t'(12'h123);
            4'h2: return rgb_t'(12'h725);  // dark purple
            4'h3: return rgb_t'(12'h085);
            4'h4: return rgb_t'(12'hA53);  // brown
            4'h5: return rgb_t'(12'h655);  // dark grey
            4'h6: return rgb_t'(12'hCCC);
            4'h7: return rgb_t'(12'hFFF);  // white
            4'h8: return rgb_t'(12'hF04);
            4'h9: return rgb_t'(12'hFA0);
            4'hA: return rgb_t'(12'hFE2);
            4'hB: return rgb_t'(12'h0E3);
            4'hC: return rgb_t'(12'h2AF);
            4'hD: return rgb_t'(12'h876);
            4'hE: return rgb_t'(12'hF7A);
            default: return rgb_t'(12'hFCA);
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/shapes_defs.svh */
// shape renderer parameters
// widths, framebuffer geometry and the shrunk raster timing
`ifndef SHAPES_DEFS_SVH
`define SHAPES_DEFS_SVH

// signed coordinate bits
`define SHP_CORDW   8
`define SHP_FB_W    32
`define SHP_FB_H    24
`define SHP_CIDXW   4
// display pixels per framebuffer pixel
`define SHP_SCALE   2

// horizontal timing in pixels
`define SHP_H_ACT   64
`define SHP_H_FP    4
`define SHP_H_SYNC  6
`define SHP_H_TOT   80

// vertical timing in lines
`define SHP_V_ACT   48
`define SHP_V_FP    2
`define SHP_V_SYNC  2
`define SHP_V_TOT   56

`endif
